// File: afu_top.f
+incdir+include
source/afu_pkg.sv
source/afu_line_fifo.sv
source/afu_mmio_regs.sv
source/afu_cmd_fsm.sv
source/afu_local_mem_port.sv
source/afu_host_to_mem.sv
source/afu_mem_to_host.sv
source/afu_top.sv
testbench/afu_assert.sv
testbench/afu_tb.sv

// File: testbench/afu_tb.sv
`timescale 1ns/1ps
`include "afu_cfg.svh"

module afu_tb;
  import afu_pkg::*;

  typedef struct {
    string      name;
    logic [2:0] cmd;
    int         io_addr;
    int         mem_addr;
    int         size;
    bit         bp;
    int         exp_lines;  // Lines expected at the destination
  } test_row_t;

  localparam int MEM_WORDS = 1024;
  localparam int NUM_TESTS = 6;

  logic                   clk;
  logic                   reset;
  mmio_req_t              mmio;
  mmio_rsp_t              mmio_rsp;
  host_rd_req_t           host_rd;
  host_rd_rsp_t           host_rd_rsp;
  logic                   host_rd_alm_full;
  host_wr_req_t           host_wr;
  logic                   host_wr_alm_full;
  logic                   host_wr_rsp_valid;
  avs_req_t               avs;
  logic                   avs_waitrequest;
  logic                   avs_readdatavalid;
  logic [`AFU_LINE_W-1:0] avs_readdata;

  logic [`AFU_LINE_W-1:0] host_mem  [MEM_WORDS];
  logic [`AFU_LINE_W-1:0] local_mem [MEM_WORDS];
  test_row_t              tests [NUM_TESTS];

  bit bp_en         = 1'b0;
  int cyc           = 0;
  int cur_size      = 0;
  int host_rd_count = 0;
  int error_count   = 0;
  int tests_run     = 0;
  int tests_failed  = 0;
  bit timed_out     = 1'b0;

  int                          mem_rd_due  [$];  // Cycle each local read returns
  logic [`AFU_MEM_ADDR_W-1:0]  mem_rd_addr [$];
  int                          ack_due     [$];
  logic [`AFU_HOST_ADDR_W-1:0] win_addr    [$];  // Current host read window
  host_tag_t                   win_tag     [$];
  logic [`AFU_HOST_ADDR_W-1:0] rsp_addr    [$];
  host_tag_t                   rsp_tag     [$];

  afu_top i_dut (
    .clk               (clk),
    .reset             (reset),
    .mmio              (mmio),
    .mmio_rsp          (mmio_rsp),
    .host_rd           (host_rd),
    .host_rd_rsp       (host_rd_rsp),
    .host_rd_alm_full  (host_rd_alm_full),
    .host_wr           (host_wr),
    .host_wr_alm_full  (host_wr_alm_full),
    .host_wr_rsp_valid (host_wr_rsp_valid),
    .avs               (avs),
    .avs_waitrequest   (avs_waitrequest),
    .avs_readdatavalid (avs_readdatavalid),
    .avs_readdata      (avs_readdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [63:0] host_word(input int a);
    return {32'h5a5a_0000 ^ a, ~a};
  endfunction

  function automatic logic [63:0] local_word(input int a);
    return {~a, 32'h0f0f_0000 ^ (a * 7)};
  endfunction

  // Requests taken at the rising edge
  initial begin
    forever begin
      @(posedge clk);
      cyc++;
      if (!reset) begin
        if (avs.read && !avs_waitrequest) begin
          mem_rd_due.push_back(cyc + 2);
          mem_rd_addr.push_back(avs.address);
        end
        if (avs.write && !avs_waitrequest) local_mem[avs.address] = avs.writedata;
        if (host_wr.valid && !host_wr_alm_full) begin
          host_mem[host_wr.addr] = host_wr.data;
          ack_due.push_back(cyc + 3);
        end
        if (host_rd.valid && !host_rd_alm_full) begin
          win_addr.push_back(host_rd.addr);
          win_tag.push_back(host_rd.tag);
          host_rd_count++;
          // Window closes on its last tag or the last line of the copy
          if (host_rd.tag == host_tag_t'(`AFU_HOST_RD_WINDOW - 1)
              || host_rd_count == cur_size) begin
            while (win_addr.size() > 0) begin
              rsp_addr.push_back(win_addr.pop_back());  // Reverse tag order
              rsp_tag.push_back(win_tag.pop_back());
            end
          end
        end
      end
    end
  end

  // Responses and back-pressure driven on the falling edge
  initial begin
    void'($urandom(32'h6881));
    host_rd_rsp       = '0;
    host_rd_alm_full  = 1'b0;
    host_wr_alm_full  = 1'b0;
    host_wr_rsp_valid = 1'b0;
    avs_waitrequest   = 1'b0;
    avs_readdatavalid = 1'b0;
    avs_readdata      = '0;
    forever begin
      @(negedge clk);
      avs_waitrequest   = bp_en && ($urandom % 3 == 0);
      host_rd_alm_full  = bp_en && ($urandom % 3 == 0);
      host_wr_alm_full  = bp_en && ($urandom % 3 == 0);
      avs_readdatavalid = 1'b0;
      if (mem_rd_due.size() > 0 && mem_rd_due[0] == cyc + 1) begin
        void'(mem_rd_due.pop_front());
        avs_readdatavalid = 1'b1;
        avs_readdata      = local_mem[mem_rd_addr.pop_front()];
      end
      host_wr_rsp_valid = 1'b0;
      if (ack_due.size() > 0 && ack_due[0] <= cyc + 1) begin
        void'(ack_due.pop_front());
        host_wr_rsp_valid = 1'b1;
      end
      host_rd_rsp.valid = 1'b0;
      if (rsp_addr.size() > 0) begin
        host_rd_rsp.valid = 1'b1;
        host_rd_rsp.tag   = rsp_tag.pop_front();
        host_rd_rsp.data  = host_mem[rsp_addr.pop_front()];
      end
    end
  end

  task automatic value_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic write_reg(input logic [15:0] addr, input logic [63:0] data);
    @(negedge clk);
    mmio.wr_valid = 1'b1;
    mmio.addr     = addr;
    mmio.data     = data;
    @(negedge clk);
    mmio.wr_valid = 1'b0;
  endtask

  // Response is due exactly one cycle after the request
  task automatic read_reg(input logic [15:0] addr, input logic [8:0] tid,
                          output logic [63:0] data, output bit ok);
    @(negedge clk);
    mmio.rd_valid = 1'b1;
    mmio.addr     = addr;
    mmio.tid      = tid;
    @(negedge clk);
    mmio.rd_valid = 1'b0;
    ok   = mmio_rsp.valid && (mmio_rsp.tid == tid);
    data = mmio_rsp.data;
  endtask

  task automatic check_read(input logic [15:0] addr, input logic [8:0] tid,
                            input logic [63:0] expected, input string what);
    logic [63:0] data;
    bit          ok;
    read_reg(addr, tid, data, ok);
    if (!ok) begin
      value_error($sformatf("%s read gave no response with tid %h", what, tid));
    end else if (data !== expected) begin
      value_error($sformatf("%s read %h, expected %h", what, data, expected));
    end
  endtask

  task automatic wait_idle(output bit ok);
    logic [63:0] data;
    bit          rd_ok;
    int          polls;
    ok = 1'b0;
    for (polls = 0; polls < 2000 && !ok; polls++) begin
      read_reg(`AFU_MMIO_STATUS, 9'(polls), data, rd_ok);
      if (rd_ok && data == 64'(STATE_IDLE)) ok = 1'b1;
    end
  endtask

  task automatic init_memories();
    int a;
    for (a = 0; a < MEM_WORDS; a++) begin
      host_mem[a]  = host_word(a);
      local_mem[a] = local_word(a);
    end
  endtask

  // Whole memories are compared so stray writes show up too
  task automatic check_memories(input test_row_t row);
    logic [63:0] exp_host;
    logic [63:0] exp_local;
    int          a;
    for (a = 0; a < MEM_WORDS; a++) begin
      exp_host  = host_word(a);
      exp_local = local_word(a);
      if (row.cmd == CMD_MEM_WRITE && a >= row.mem_addr && a < row.mem_addr + row.exp_lines)
        exp_local = host_word(row.io_addr + a - row.mem_addr);
      if (row.cmd == CMD_MEM_READ && a >= row.io_addr && a < row.io_addr + row.exp_lines)
        exp_host = local_word(row.mem_addr + a - row.io_addr);
      if (local_mem[a] !== exp_local)
        value_error($sformatf("local line %0d is %h, expected %h", a, local_mem[a], exp_local));
      if (host_mem[a] !== exp_host)
        value_error($sformatf("host line %0d is %h, expected %h", a, host_mem[a], exp_host));
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (error_count == errs_before) ? "ok" : "bad");
  endtask

  initial begin
    test_row_t row;
    int        errs_before;
    int        i;
    bit        idle_ok;
    reset    = 1'b1;
    mmio     = '0;
    tests[0] = '{"host to local 20 lines", CMD_MEM_WRITE, 16, 40, 20, 1'b0, 20};
    tests[1] = '{"local to host 20 lines", CMD_MEM_READ, 100, 200, 20, 1'b0, 20};
    tests[2] = '{"size 0 copy", CMD_MEM_WRITE, 300, 500, 0, 1'b0, 0};
    tests[3] = '{"unknown command", 3'd5, 400, 600, 12, 1'b0, 0};
    tests[4] = '{"host to local with back-pressure", CMD_MEM_WRITE, 16, 40, 20, 1'b1, 20};
    tests[5] = '{"local to host with back-pressure", CMD_MEM_READ, 100, 200, 20, 1'b1, 20};
    init_memories();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    errs_before = error_count;
    check_read(`AFU_MMIO_ID_L, 9'h1a5, `AFU_ID_LO, "ID_L");
    check_read(`AFU_MMIO_ID_H, 9'h03c, `AFU_ID_HI, "ID_H");
    check_read(`AFU_MMIO_STATUS, 9'h0f0, 64'(STATE_IDLE), "status");
    check_read(16'h0020, 9'h155, 64'h0, "unmapped");
    finish_test("ID words and status after reset", errs_before);

    for (i = 0; i < NUM_TESTS && !timed_out; i++) begin
      row           = tests[i];
      errs_before   = error_count;
      init_memories();
      bp_en         = row.bp;
      cur_size      = row.size;
      host_rd_count = 0;
      write_reg(`AFU_MMIO_IO_ADDR, 64'(row.io_addr));
      write_reg(`AFU_MMIO_MEM_ADDR, 64'(row.mem_addr));
      write_reg(`AFU_MMIO_DATA_SIZE, 64'(row.size));
      write_reg(`AFU_MMIO_CMD_TYPE, 64'(row.cmd));
      wait_idle(idle_ok);
      bp_en = 1'b0;
      if (idle_ok) begin
        check_memories(row);
      end else begin
        $display("Timeout: status never returned to idle during %s", row.name);
        error_count++;
        timed_out = 1'b1;
      end
      finish_test(row.name, errs_before);
    end

    error_count += i_dut.i_afu_assert.fail_count;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/afu_assert.sv
`timescale 1ns/1ps

module afu_assert (
  input logic                  clk,
  input logic                  reset,
  input afu_pkg::mmio_req_t    mmio,
  input afu_pkg::mmio_rsp_t    mmio_rsp,
  input afu_pkg::host_rd_req_t host_rd,
  input logic                  host_rd_alm_full,
  input afu_pkg::avs_req_t     avs
);
  int fail_count = 0;

  // One Avalon operation per cycle
  avs_one_op: assert property (@(posedge clk) disable iff (reset)
    !(avs.read && avs.write))
  else begin
    $error("avs read and write high together");
    fail_count++;
  end

  host_rd_no_rise_on_full: assert property (@(posedge clk) disable iff (reset)
    $rose(host_rd.valid) |-> !host_rd_alm_full)
  else begin
    $error("host_rd valid rose while alm_full high");
    fail_count++;
  end

  mmio_rsp_next_cycle: assert property (@(posedge clk) disable iff (reset)
    mmio.rd_valid |=> (mmio_rsp.valid && (mmio_rsp.tid == $past(mmio.tid))))
  else begin
    $error("mmio_rsp missing or wrong tid one cycle after read");
    fail_count++;
  end

endmodule

bind afu_top afu_assert i_afu_assert (
  .clk              (clk),
  .reset            (reset),
  .mmio             (mmio),
  .mmio_rsp         (mmio_rsp),
  .host_rd          (host_rd),
  .host_rd_alm_full (host_rd_alm_full),
  .avs              (avs)
);

// File: source/afu_top.sv
`timescale 1ns/1ps
`include "afu_cfg.svh"

module afu_top (
  input  logic                   clk,
  input  logic                   reset,
  input  afu_pkg::mmio_req_t     mmio,
  output afu_pkg::mmio_rsp_t     mmio_rsp,
  output afu_pkg::host_rd_req_t  host_rd,
  input  afu_pkg::host_rd_rsp_t  host_rd_rsp,
  input  logic                   host_rd_alm_full,
  output afu_pkg::host_wr_req_t  host_wr,
  input  logic                   host_wr_alm_full,
  input  logic                   host_wr_rsp_valid,
  output afu_pkg::avs_req_t      avs,
  input  logic                   avs_waitrequest,
  input  logic                   avs_readdatavalid,
  input  logic [`AFU_LINE_W-1:0] avs_readdata
);
  import afu_pkg::*;

  copy_cmd_t                  copy_cmd;
  logic                       cmd_valid;
  cmd_e                       cmd;
  state_e                     state;
  logic                       read_start;
  logic                       write_start;
  logic                       rd_done;
  logic                       wr_done;
  mem_wr_t                    mem_wr;
  logic                       wr_taken;
  logic                       rd_valid;
  logic [`AFU_MEM_ADDR_W-1:0] rd_addr;
  logic                       rd_taken;
  logic [`AFU_LINE_W-1:0]     rd_data;
  logic                       rd_empty;
  logic                       rd_pop;

  afu_mmio_regs i_mmio_regs (
    .clk       (clk),
    .reset     (reset),
    .mmio      (mmio),
    .mmio_rsp  (mmio_rsp),
    .state     (state),
    .copy_cmd  (copy_cmd),
    .cmd_valid (cmd_valid),
    .cmd       (cmd)
  );

  afu_cmd_fsm i_cmd_fsm (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .rd_done     (rd_done),
    .wr_done     (wr_done),
    .state       (state),
    .read_start  (read_start),
    .write_start (write_start)
  );

  // Host to local copy
  afu_host_to_mem i_host_to_mem (
    .clk              (clk),
    .reset            (reset),
    .start            (write_start),
    .copy_cmd         (copy_cmd),
    .host_rd          (host_rd),
    .host_rd_alm_full (host_rd_alm_full),
    .host_rd_rsp      (host_rd_rsp),
    .mem_wr           (mem_wr),
    .wr_taken         (wr_taken),
    .done             (wr_done)
  );

  // Local to host copy
  afu_mem_to_host i_mem_to_host (
    .clk               (clk),
    .reset             (reset),
    .start             (read_start),
    .copy_cmd          (copy_cmd),
    .rd_valid          (rd_valid),
    .rd_addr           (rd_addr),
    .rd_taken          (rd_taken),
    .rd_data           (rd_data),
    .rd_empty          (rd_empty),
    .rd_pop            (rd_pop),
    .host_wr           (host_wr),
    .host_wr_alm_full  (host_wr_alm_full),
    .host_wr_rsp_valid (host_wr_rsp_valid),
    .done              (rd_done)
  );

  afu_local_mem_port i_local_mem_port (
    .clk               (clk),
    .reset             (reset),
    .state             (state),
    .mem_wr            (mem_wr),
    .wr_taken          (wr_taken),
    .rd_valid          (rd_valid),
    .rd_addr           (rd_addr),
    .rd_taken          (rd_taken),
    .rd_data           (rd_data),
    .rd_empty          (rd_empty),
    .rd_pop            (rd_pop),
    .avs               (avs),
    .avs_waitrequest   (avs_waitrequest),
    .avs_readdatavalid (avs_readdatavalid),
    .avs_readdata      (avs_readdata)
  );

endmodule

// File: source/afu_mem_to_host.sv
`timescale 1ns/1ps
`include "afu_cfg.svh"

module afu_mem_to_host (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  afu_pkg::copy_cmd_t         copy_cmd,
  output logic                       rd_valid,
  output logic [`AFU_MEM_ADDR_W-1:0] rd_addr,
  input  logic                       rd_taken,
  input  logic [`AFU_LINE_W-1:0]     rd_data,
  input  logic                       rd_empty,
  output logic                       rd_pop,
  output afu_pkg::host_wr_req_t      host_wr,
  input  logic                       host_wr_alm_full,
  input  logic                       host_wr_rsp_valid,
  output logic                       done
);
  import afu_pkg::*;

  logic [`AFU_SIZE_W-1:0]                rd_left;
  logic [`AFU_HOST_ADDR_W-1:0]           wr_addr;
  logic [`AFU_SIZE_W-1:0]                wr_left;
  logic [$clog2(`AFU_HOST_WR_MAX+1)-1:0] wr_pending;  // Writes not yet acknowledged
  logic                                  wr_fire;

  assign rd_valid = (rd_left != 0);
  assign wr_fire  = !rd_empty && (wr_left != 0) && !host_wr_alm_full
                 && (wr_pending < `AFU_HOST_WR_MAX);
  assign rd_pop   = wr_fire;
  assign done     = (wr_left == 0) && (wr_pending == 0);

  always_comb begin
    host_wr.valid = wr_fire;
    host_wr.addr  = wr_addr;
    host_wr.data  = rd_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr    <= '0;
      rd_left    <= '0;
      wr_addr    <= '0;
      wr_left    <= '0;
      wr_pending <= '0;
    end else begin
      if (start) begin
        rd_addr <= copy_cmd.mem_addr;
        rd_left <= copy_cmd.size;
        wr_addr <= copy_cmd.io_addr;
        wr_left <= copy_cmd.size;
      end else begin
        if (rd_taken) begin
          rd_addr <= rd_addr + 1'b1;
          rd_left <= rd_left - 1'b1;
        end
        if (wr_fire) begin
          wr_addr <= wr_addr + 1'b1;
          wr_left <= wr_left - 1'b1;
        end
      end
      wr_pending <= wr_pending + wr_fire - host_wr_rsp_valid;
    end
  end

endmodule

// File: source/afu_host_to_mem.sv
`timescale 1ns/1ps
`include "afu_cfg.svh"

module afu_host_to_mem (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  afu_pkg::copy_cmd_t    copy_cmd,
  output afu_pkg::host_rd_req_t host_rd,
  input  logic                  host_rd_alm_full,
  input  afu_pkg::host_rd_rsp_t host_rd_rsp,
  output afu_pkg::mem_wr_t      mem_wr,
  input  logic                  wr_taken,
  output logic                  done
);
  import afu_pkg::*;

  logic [`AFU_SIZE_W-1:0]      size;
  logic [`AFU_HOST_ADDR_W-1:0] rd_addr;
  logic [`AFU_SIZE_W-1:0]      rd_ctr;
  logic                        rd_wait;  // Waiting on responses to a full window
  host_tag_t                   rsp_ctr;
  logic [`AFU_SIZE_W-1:0]      wr_ctr;
  logic [`AFU_MEM_ADDR_W-1:0]  wr_base;
  logic                        rd_fire;
  logic                        q_empty;
  host_tag_t                   q_tag;
  logic [`AFU_LINE_W-1:0]      q_data;
  logic [`AFU_LINE_W+$bits(host_tag_t)-1:0] q_dout;

  // Lines not yet written stay under the queue depth of two windows
  assign rd_fire = (rd_ctr < size) && !rd_wait && !host_rd_alm_full
                && ((rd_ctr - wr_ctr) < 2 * `AFU_HOST_RD_WINDOW);

  assign {q_data, q_tag} = q_dout;
  assign done = (wr_ctr == size);

  always_comb begin
    host_rd.valid = rd_fire;
    host_rd.addr  = rd_addr;
    host_rd.tag   = host_tag_t'(rd_ctr);
    mem_wr.valid  = !q_empty;
    mem_wr.addr   = wr_base + q_tag;  // Tag orders lines inside the window
    mem_wr.data   = q_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      size    <= '0;
      rd_addr <= '0;
      rd_ctr  <= '0;
      rd_wait <= 1'b0;
      rsp_ctr <= '0;
      wr_ctr  <= '0;
      wr_base <= '0;
    end else if (start) begin
      size    <= copy_cmd.size;
      rd_addr <= copy_cmd.io_addr;
      rd_ctr  <= '0;
      rd_wait <= 1'b0;
      rsp_ctr <= '0;
      wr_ctr  <= '0;
      wr_base <= copy_cmd.mem_addr;
    end else begin
      if (rd_fire) begin
        rd_addr <= rd_addr + 1'b1;
        rd_ctr  <= rd_ctr + 1'b1;
        if (host_tag_t'(rd_ctr) == host_tag_t'(`AFU_HOST_RD_WINDOW - 1)) rd_wait <= 1'b1;
      end
      if (host_rd_rsp.valid) begin
        rsp_ctr <= rsp_ctr + 1'b1;
        if (rsp_ctr == host_tag_t'(`AFU_HOST_RD_WINDOW - 1)) rd_wait <= 1'b0;
      end
      if (wr_taken) begin
        wr_ctr <= wr_ctr + 1'b1;
        if (host_tag_t'(wr_ctr) == host_tag_t'(`AFU_HOST_RD_WINDOW - 1)) begin
          wr_base <= wr_base + `AFU_HOST_RD_WINDOW;
        end
      end
    end
  end

  afu_line_fifo #(
    .WIDTH (`AFU_LINE_W + $bits(host_tag_t)),
    .DEPTH (2 * `AFU_HOST_RD_WINDOW)
  ) i_rd_queue (
    .clk   (clk),
    .reset (reset),
    .push  (host_rd_rsp.valid),
    .din   ({host_rd_rsp.data, host_rd_rsp.tag}),
    .pop   (wr_taken),
    .dout  (q_dout),
    .empty (q_empty),
    .full  ()
  );

endmodule

// File: source/afu_local_mem_port.sv
`timescale 1ns/1ps
`include "afu_cfg.svh"

module afu_local_mem_port (
  input  logic                       clk,
  input  logic                       reset,
  input  afu_pkg::state_e            state,
  input  afu_pkg::mem_wr_t           mem_wr,
  output logic                       wr_taken,
  input  logic                       rd_valid,
  input  logic [`AFU_MEM_ADDR_W-1:0] rd_addr,
  output logic                       rd_taken,
  output logic [`AFU_LINE_W-1:0]     rd_data,
  output logic                       rd_empty,
  input  logic                       rd_pop,
  output afu_pkg::avs_req_t          avs,
  input  logic                       avs_waitrequest,
  input  logic                       avs_readdatavalid,
  input  logic [`AFU_LINE_W-1:0]     avs_readdata
);
  import afu_pkg::*;

  logic [$clog2(`AFU_MEM_RD_QUEUE+1)-1:0] rd_pending;  // Taken but not yet popped
  logic                                   rd_en;
  logic                                   wr_en;

  // Port owner follows the command state
  assign rd_en = (state == STATE_READ) && rd_valid && (rd_pending < `AFU_MEM_RD_QUEUE);
  assign wr_en = (state == STATE_WRITE) && mem_wr.valid;

  assign rd_taken = rd_en && !avs_waitrequest;
  assign wr_taken = wr_en && !avs_waitrequest;

  always_comb begin
    avs.read      = rd_en;
    avs.write     = wr_en;
    avs.address   = wr_en ? mem_wr.addr : rd_addr;
    avs.writedata = mem_wr.data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pending <= '0;
    end else begin
      rd_pending <= rd_pending + rd_taken - rd_pop;
    end
  end

  // Pending limit equals the depth so it never overflows
  afu_line_fifo #(
    .WIDTH (`AFU_LINE_W),
    .DEPTH (`AFU_MEM_RD_QUEUE)
  ) i_rd_queue (
    .clk   (clk),
    .reset (reset),
    .push  (avs_readdatavalid),
    .din   (avs_readdata),
    .pop   (rd_pop),
    .dout  (rd_data),
    .empty (rd_empty),
    .full  ()
  );

endmodule

// File: source/afu_cmd_fsm.sv
`timescale 1ns/1ps

module afu_cmd_fsm (
  input  logic            clk,
  input  logic            reset,
  input  logic            cmd_valid,
  input  afu_pkg::cmd_e   cmd,
  input  logic            rd_done,
  input  logic            wr_done,
  output afu_pkg::state_e state,
  output logic            read_start,
  output logic            write_start
);
  import afu_pkg::*;

  // Commands only start from idle; anything else is dropped
  assign read_start  = cmd_valid && (state == STATE_IDLE) && (cmd == CMD_MEM_READ);
  assign write_start = cmd_valid && (state == STATE_IDLE) && (cmd == CMD_MEM_WRITE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= STATE_IDLE;
    end else begin
      case (state)
        STATE_IDLE: begin
          if (read_start) begin
            state <= STATE_READ;
          end else if (write_start) begin
            state <= STATE_WRITE;
          end
        end
        STATE_READ:  if (rd_done) state <= STATE_IDLE;
        STATE_WRITE: if (wr_done) state <= STATE_IDLE;
        default:     state <= STATE_IDLE;
      endcase
    end
  end

endmodule

// File: source/afu_mmio_regs.sv
`timescale 1ns/1ps
`include "afu_cfg.svh"

module afu_mmio_regs (
  input  logic               clk,
  input  logic               reset,
  input  afu_pkg::mmio_req_t mmio,
  output afu_pkg::mmio_rsp_t mmio_rsp,
  input  afu_pkg::state_e    state,
  output afu_pkg::copy_cmd_t copy_cmd,
  output logic               cmd_valid,
  output afu_pkg::cmd_e      cmd
);
  import afu_pkg::*;

  logic        rsp_valid;
  logic [8:0]  rsp_tid;
  logic [63:0] rsp_data;

  assign cmd_valid = mmio.wr_valid && (mmio.addr == `AFU_MMIO_CMD_TYPE);
  assign cmd       = cmd_valid ? cmd_e'(mmio.data[2:0]) : CMD_NONE;

  always_ff @(posedge clk) begin
    if (reset) begin
      copy_cmd <= '0;
    end else if (mmio.wr_valid) begin
      case (mmio.addr)
        `AFU_MMIO_IO_ADDR:   copy_cmd.io_addr  <= mmio.data[`AFU_HOST_ADDR_W-1:0];
        `AFU_MMIO_MEM_ADDR:  copy_cmd.mem_addr <= mmio.data[`AFU_MEM_ADDR_W-1:0];
        `AFU_MMIO_DATA_SIZE: copy_cmd.size     <= mmio.data[`AFU_SIZE_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= mmio.rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mmio.rd_valid) begin
      rsp_tid <= mmio.tid;  // Echo request tid
      case (mmio.addr)
        `AFU_MMIO_DFH:    rsp_data <= 64'h1000_0100_0000_0000;  // AFU type, last in list
        `AFU_MMIO_ID_L:   rsp_data <= `AFU_ID_LO;
        `AFU_MMIO_ID_H:   rsp_data <= `AFU_ID_HI;
        `AFU_MMIO_STATUS: rsp_data <= 64'(state);
        default:          rsp_data <= 64'h0;
      endcase
    end
  end

  always_comb begin
    mmio_rsp.valid = rsp_valid;
    mmio_rsp.tid   = rsp_tid;
    mmio_rsp.data  = rsp_data;
  end

endmodule

// File: source/afu_line_fifo.sv
`timescale 1ns/1ps

module afu_line_fifo #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic [WIDTH-1:0] din,
  input  logic             pop,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full
);
  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW:0]      wr_ptr;  // Extra bit tells full from empty
  logic [AW:0]      rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign dout  = mem[rd_ptr[AW-1:0]];  // Head is visible without a pop

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) mem[wr_ptr[AW-1:0]] <= din;
  end

endmodule

// File: source/afu_pkg.sv
`include "afu_cfg.svh"

package afu_pkg;

  typedef enum logic [2:0] {
    CMD_NONE      = 3'd0,
    CMD_MEM_READ  = 3'd1,  // Local to host
    CMD_MEM_WRITE = 3'd2   // Host to local
  } cmd_e;

  typedef enum logic [3:0] {
    STATE_IDLE  = 4'd0,
    STATE_READ  = 4'd1,
    STATE_WRITE = 4'd2
  } state_e;

  typedef logic [$clog2(`AFU_HOST_RD_WINDOW)-1:0] host_tag_t;

  typedef struct packed {
    logic                        wr_valid;
    logic                        rd_valid;
    logic [`AFU_MMIO_ADDR_W-1:0] addr;
    logic [8:0]                  tid;
    logic [63:0]                 data;
  } mmio_req_t;

  typedef struct packed {
    logic        valid;
    logic [8:0]  tid;
    logic [63:0] data;
  } mmio_rsp_t;

  typedef struct packed {
    logic [`AFU_HOST_ADDR_W-1:0] io_addr;
    logic [`AFU_MEM_ADDR_W-1:0]  mem_addr;
    logic [`AFU_SIZE_W-1:0]      size;
  } copy_cmd_t;

  typedef struct packed {
    logic                        valid;
    logic [`AFU_HOST_ADDR_W-1:0] addr;
    host_tag_t                   tag;
  } host_rd_req_t;

  typedef struct packed {
    logic                   valid;
    host_tag_t              tag;
    logic [`AFU_LINE_W-1:0] data;
  } host_rd_rsp_t;

  typedef struct packed {
    logic                        valid;
    logic [`AFU_HOST_ADDR_W-1:0] addr;
    logic [`AFU_LINE_W-1:0]      data;
  } host_wr_req_t;

  typedef struct packed {
    logic                       valid;
    logic [`AFU_MEM_ADDR_W-1:0] addr;
    logic [`AFU_LINE_W-1:0]     data;
  } mem_wr_t;

  typedef struct packed {
    logic                       read;
    logic                       write;
    logic [`AFU_MEM_ADDR_W-1:0] address;
    logic [`AFU_LINE_W-1:0]     writedata;
  } avs_req_t;

endpackage

// File: include/afu_cfg.svh
`ifndef AFU_CFG_SVH
`define AFU_CFG_SVH

`define AFU_LINE_W          64
`define AFU_MEM_ADDR_W      16
`define AFU_HOST_ADDR_W     20
`define AFU_SIZE_W          16
`define AFU_MMIO_ADDR_W     16

`define AFU_MEM_RD_QUEUE    16  // Local reads in flight
`define AFU_HOST_RD_WINDOW  8   // Host reads per tag window
`define AFU_HOST_WR_MAX     64

`define AFU_MMIO_DFH        16'h0000
`define AFU_MMIO_ID_L       16'h0002
`define AFU_MMIO_ID_H       16'h0004
`define AFU_MMIO_STATUS     16'h000a
`define AFU_MMIO_IO_ADDR    16'h000c
`define AFU_MMIO_MEM_ADDR   16'h000e
`define AFU_MMIO_DATA_SIZE  16'h0010
`define AFU_MMIO_CMD_TYPE   16'h0012

`define AFU_ID_LO           64'h9f81_2c40_5be7_3a16
`define AFU_ID_HI           64'h4d3b_e0a7_61c2_58f9

`endif
